/* Makefile */
# Verilator build and run for the core testbench

VERILATOR ?= verilator
TOP ?= cpuTb
FLIST ?= flist.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
PASS_TEXT ?= All checks passed

SOURCES := $(filter-out +%,$(shell cat $(FLIST)))
HEADERS := $(wildcard hw/*.svh bench/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/cpuTests.svh */
//--------------------------------------------------------------------
// Directed tests, instruction encoders and model helpers for the core
// Included inside the testbench module body
//--------------------------------------------------------------------

//--------------------------------------------------------------------
// Instruction encoders
//--------------------------------------------------------------------
function automatic wordT encAluReg(input cpuPkg::opcodeT op, input int dr, input int sr1,
	input int sr2);
	return {op, 3'(dr), 3'(sr1), 3'b000, 3'(sr2)};
endfunction

function automatic wordT encAluImm(input cpuPkg::opcodeT op, input int dr, input int sr1,
	input int imm);
	return {op, 3'(dr), 3'(sr1), 1'b1, 5'(imm)};
endfunction

function automatic wordT encNot(input int dr, input int sr);
	return {cpuPkg::opNot, 3'(dr), 3'(sr), 6'b111111};
endfunction

function automatic wordT encBr(input logic [2:0] nzp, input int off);
	return {cpuPkg::opBr, nzp, 9'(off)};
endfunction

function automatic wordT encJmp(input int base);
	return {cpuPkg::opJmp, 3'b000, 3'(base), 6'b000000};
endfunction

function automatic wordT encJsr(input int off);
	return {cpuPkg::opJsr, 1'b1, 11'(off)};
endfunction

function automatic wordT encJsrr(input int base);
	return {cpuPkg::opJsr, 3'b000, 3'(base), 6'b000000};
endfunction

// LDR and STR share one layout
function automatic wordT encMem(input cpuPkg::opcodeT op, input int r, input int base,
	input int off);
	return {op, 3'(r), 3'(base), 6'(off)};
endfunction

function automatic wordT encPause(input logic [11:0] code);
	return {cpuPkg::opPause, code};
endfunction

//--------------------------------------------------------------------
// Model helpers
//--------------------------------------------------------------------
function automatic addrT memAt(input int base, input int off);
	return addrT'(base + off);			// Word address wraps in memory
endfunction

function automatic logic [2:0] ccOf(input wordT value);
	if (value[`CPU_WORD_WIDTH-1])
		return 3'b100;
	else if (value == '0)
		return 3'b010;
	else
		return 3'b001;
endfunction

//--------------------------------------------------------------------
// Tests
//--------------------------------------------------------------------
task automatic testResetState();
	wordT word;
	wordT got;
	word = wordT'($urandom);
	prog.delete();
	prog.push_back(encAluImm(cpuPkg::opAnd, 0, 0, 0));
	prog.push_back(encMem(cpuPkg::opStr, 0, 0, -16));	// Would overwrite the word
	prog.push_back(encPause(12'h0f5));
	loadProgram();
	hostWrite(memAt(0, -16), word);
	applyReset();
	@(negedge Clk);
	assert (paused === 1'b0)
	else
		failRun("paused is high right after reset");
	checkEqual("ledOut after reset", {4'h0, ledOut}, 16'h0000);
	repeat (50) @(posedge Clk);
	hostRead(memAt(0, -16), got);
	checkEqual("preloaded word", got, word);
	assert (paused === 1'b0)
	else
		failRun("Core left halted without run");
endtask

task automatic testAluOps();
	wordT a;
	wordT b;
	wordT got;
	int imm;
	a = wordT'($urandom);
	b = wordT'($urandom);
	imm = -1 - int'($urandom_range(15, 0));		// -16 .. -1
	prog.delete();
	prog.push_back(encAluImm(cpuPkg::opAnd, 0, 0, 0));	// R0 = 0 as data base
	prog.push_back(encMem(cpuPkg::opLdr, 1, 0, -32));
	prog.push_back(encMem(cpuPkg::opLdr, 2, 0, -31));
	prog.push_back(encAluReg(cpuPkg::opAdd, 3, 1, 2));
	prog.push_back(encMem(cpuPkg::opStr, 3, 0, -16));
	prog.push_back(encAluImm(cpuPkg::opAdd, 4, 1, imm));
	prog.push_back(encMem(cpuPkg::opStr, 4, 0, -15));
	prog.push_back(encAluReg(cpuPkg::opAnd, 5, 1, 2));
	prog.push_back(encMem(cpuPkg::opStr, 5, 0, -14));
	prog.push_back(encNot(6, 1));
	prog.push_back(encMem(cpuPkg::opStr, 6, 0, -13));
	prog.push_back(encPause(12'h0a1));
	applyReset();
	loadProgram();
	hostWrite(memAt(0, -32), a);
	hostWrite(memAt(0, -31), b);
	runToPause();
	hostRead(memAt(0, -16), got);
	checkEqual("ADD register", got, a + b);
	hostRead(memAt(0, -15), got);
	checkEqual("ADD immediate", got, wordT'(int'(a) + imm));
	hostRead(memAt(0, -14), got);
	checkEqual("AND register", got, a & b);
	hostRead(memAt(0, -13), got);
	checkEqual("NOT", got, ~a);
endtask

task automatic testBranches();
	wordT vals [3];
	wordT got;
	logic [2:0] cc;
	logic [2:0] mask;
	int count;
	int i;
	vals[0] = wordT'($urandom) | 16'h8000;		// Negative
	vals[1] = 16'h0000;
	vals[2] = (wordT'($urandom) & 16'h7fff) | 16'h0001;	// Positive
	count = 0;
	prog.delete();
	prog.push_back(encAluImm(cpuPkg::opAnd, 0, 0, 0));
	prog.push_back(encAluImm(cpuPkg::opAnd, 5, 5, 0));	// Counter
	for (i = 0; i < 6; i++)
	begin
		cc = ccOf(vals[i / 2]);
		if (i % 2 == 0)
			mask = cc | 3'($urandom);		// Taken so the increment is skipped
		else
			mask = ~cc & 3'($urandom);		// Not taken
		if ((mask & cc) == 3'b000)
			count++;
		prog.push_back(encMem(cpuPkg::opLdr, 1, 0, -32 + i / 2));	// Sets CC
		prog.push_back(encBr(mask, 1));
		prog.push_back(encAluImm(cpuPkg::opAdd, 5, 5, 1));
	end
	prog.push_back(encMem(cpuPkg::opStr, 5, 0, -16));
	prog.push_back(encPause(12'h0b2));
	applyReset();
	loadProgram();
	for (i = 0; i < 3; i++)
		hostWrite(memAt(0, -32 + i), vals[i]);
	runToPause();
	hostRead(memAt(0, -16), got);
	checkEqual("branch counter", got, wordT'(count));
endtask

task automatic testJumps();
	wordT marker;
	wordT got;
	wordT exp [7];
	int i;
	marker = wordT'($urandom);
	prog.delete();
	prog.push_back(encAluImm(cpuPkg::opAnd, 0, 0, 0));
	prog.push_back(encMem(cpuPkg::opLdr, 1, 0, -32));	// Marker
	prog.push_back(encMem(cpuPkg::opLdr, 2, 0, -31));	// JMP target
	prog.push_back(encJmp(2));					// 3 -> 5
	prog.push_back(encMem(cpuPkg::opStr, 1, 0, -16));
	prog.push_back(encMem(cpuPkg::opStr, 1, 0, -15));
	prog.push_back(encJsr(2));					// 6 -> 9 with R7 = 7
	prog.push_back(encMem(cpuPkg::opStr, 1, 0, -14));
	prog.push_back(encMem(cpuPkg::opStr, 1, 0, -13));
	prog.push_back(encMem(cpuPkg::opStr, 7, 0, -12));
	prog.push_back(encMem(cpuPkg::opLdr, 3, 0, -30));	// JSRR target
	prog.push_back(encJsrr(3));					// 11 -> 13 with R7 = 12
	prog.push_back(encMem(cpuPkg::opStr, 1, 0, -11));
	prog.push_back(encMem(cpuPkg::opStr, 7, 0, -10));
	prog.push_back(encPause(12'h0c3));
	applyReset();
	loadProgram();
	hostWrite(memAt(0, -32), marker);
	hostWrite(memAt(0, -31), 16'd5);
	hostWrite(memAt(0, -30), 16'd13);
	runToPause();
	for (i = 0; i < 7; i++)
		exp[i] = fillWord(memAt(0, -16 + i));	// Skipped slots keep the fill
	exp[1] = marker;
	exp[4] = 16'd7;
	exp[6] = 16'd12;
	for (i = 0; i < 7; i++)
	begin
		hostRead(memAt(0, -16 + i), got);
		checkEqual($sformatf("jump marker slot %0d", i), got, exp[i]);
	end
endtask

task automatic testLoadStoreOffsets();
	wordT vPos;
	wordT vNeg;
	wordT got;
	int base;
	int p;
	int p2;
	int n;
	int n2;
	base = 64 + int'($urandom_range(63, 0));
	p = 1 + int'($urandom_range(14, 0));
	p2 = 16 + int'($urandom_range(15, 0));
	n = 1 + int'($urandom_range(15, 0));
	n2 = 17 + int'($urandom_range(15, 0));
	vPos = wordT'($urandom);
	vNeg = wordT'($urandom);
	prog.delete();
	prog.push_back(encAluImm(cpuPkg::opAnd, 0, 0, 0));
	prog.push_back(encMem(cpuPkg::opLdr, 4, 0, -32));	// Base register
	prog.push_back(encMem(cpuPkg::opLdr, 1, 4, p));
	prog.push_back(encMem(cpuPkg::opLdr, 2, 4, -n));
	prog.push_back(encMem(cpuPkg::opStr, 1, 4, -n2));
	prog.push_back(encMem(cpuPkg::opStr, 2, 4, p2));
	prog.push_back(encPause(12'h0d4));
	applyReset();
	loadProgram();
	hostWrite(memAt(0, -32), wordT'(base));
	hostWrite(memAt(base, p), vPos);
	hostWrite(memAt(base, -n), vNeg);
	runToPause();
	hostRead(memAt(base, -n2), got);
	checkEqual("STR negative offset", got, vPos);
	hostRead(memAt(base, p2), got);
	checkEqual("STR positive offset", got, vNeg);
	hostRead(memAt(base, p), got);
	checkEqual("LDR source positive", got, vPos);
	hostRead(memAt(base, -n), got);
	checkEqual("LDR source negative", got, vNeg);
endtask

task automatic testPause();
	wordT marker;
	wordT got;
	logic [11:0] code1;
	logic [11:0] code2;
	int i;
	marker = wordT'($urandom);
	code1 = 12'($urandom);
	code2 = ~code1;						// Distinct from the first code
	prog.delete();
	prog.push_back(encAluImm(cpuPkg::opAnd, 0, 0, 0));
	prog.push_back(encMem(cpuPkg::opLdr, 1, 0, -32));
	prog.push_back(encPause(code1));
	prog.push_back(encMem(cpuPkg::opStr, 1, 0, -16));
	prog.push_back(encPause(code2));
	applyReset();
	loadProgram();
	hostWrite(memAt(0, -32), marker);
	runToPause();
	checkEqual("ledOut first PAUSE", {4'h0, ledOut}, {4'h0, code1});

	// Core must stay parked while resume is held
	@(posedge Clk);
	resume <= 1'b1;
	for (i = 0; i < 10; i++)
	begin
		@(negedge Clk);
		assert (paused === 1'b1)
		else
			failRun("paused dropped while resume was held high");
	end
	hostRead(memAt(0, -16), got);
	checkEqual("store before release", got, fillWord(memAt(0, -16)));

	@(posedge Clk);
	resume <= 1'b0;						// Release lets it go on
	waitPaused(1'b0);
	waitPaused(1'b1);
	checkEqual("ledOut second PAUSE", {4'h0, ledOut}, {4'h0, code2});
	hostRead(memAt(0, -16), got);
	checkEqual("store after release", got, marker);
endtask

/* bench/cpuTb.sv */
//--------------------------------------------------------------------
// Testbench top for the core, with clock, reset, host port helpers
// Directed tests come from the included task file
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "cpuConsts.svh"

module cpuTb;

	typedef logic [`CPU_WORD_WIDTH-1:0] wordT;
	typedef logic [`CPU_MEM_ADDR_WIDTH-1:0] addrT;

	localparam int ClkPeriod = 20;
	localparam int ResetCycles = 16;
	localparam int PauseTimeout = 1000;		// Cycles, longest program is ~250
	localparam int MemWords = 1 << `CPU_MEM_ADDR_WIDTH;
	localparam logic [31:0] Seed = 32'h98a5_b401;

	logic Clk;
	logic rstN;
	logic run;
	logic resume;
	logic hostWe;
	addrT hostAddr;
	wordT hostWrData;
	logic [11:0] ledOut;
	logic paused;
	wordT hostRdData;

	wordT prog [$];							// Program image, loaded from address 0

	cpuTop dut (.*);

	always #(ClkPeriod / 2) Clk = ~Clk;

	//--------------------------------------------------------------------
	// Failure reporting and checks
	//--------------------------------------------------------------------
	task automatic failRun(input string msg);
		$display("%s", msg);
		$display("Checks failed");
		$fatal(1, "Stopping at first failure");
	endtask

	task automatic checkEqual(input string what, input wordT got, input wordT exp);
		assert (got === exp)
		else
			failRun($sformatf("Mismatch at %0t ns: %s got %h expected %h",
				$time, what, got, exp));
	endtask

	//--------------------------------------------------------------------
	// Reset, host port and run control
	//--------------------------------------------------------------------
	task automatic applyReset();
		@(posedge Clk);
		rstN <= 1'b0;
		run <= 1'b0;						// Core must come up halted
		resume <= 1'b0;
		hostWe <= 1'b0;
		repeat (ResetCycles) @(posedge Clk);
		rstN <= 1'b1;
		@(posedge Clk);
	endtask

	task automatic hostWrite(input addrT addr, input wordT data);
		@(posedge Clk);
		hostWe <= 1'b1;
		hostAddr <= addr;
		hostWrData <= data;
		@(posedge Clk);						// Write lands here
		hostWe <= 1'b0;
	endtask

	task automatic hostRead(input addrT addr, output wordT data);
		@(posedge Clk);
		hostAddr <= addr;
		@(posedge Clk);						// Registered read
		@(negedge Clk);
		data = hostRdData;
	endtask

	// Every word gets a pattern from its own address, then the program
	function automatic wordT fillWord(input addrT addr);
		return wordT'({addr, ~addr});
	endfunction

	task automatic loadProgram();
		int i;
		for (i = 0; i < MemWords; i++)
			hostWrite(addrT'(i), fillWord(addrT'(i)));
		for (i = 0; i < prog.size(); i++)
			hostWrite(addrT'(i), prog[i]);
	endtask

	task automatic waitPaused(input logic level);
		int cycles;
		cycles = 0;
		@(negedge Clk);
		while (paused !== level)
		begin
			if (cycles == PauseTimeout)
				failRun($sformatf("Timed out waiting for paused to become %0b", level));
			cycles++;
			@(negedge Clk);
		end
		if (level)
			@(negedge Clk);					// LED register loads in first pause cycle
	endtask

	task automatic runToPause();
		@(posedge Clk);
		run <= 1'b1;
		waitPaused(1'b1);
	endtask

	`include "cpuTests.svh"

	//--------------------------------------------------------------------
	// Test sequence
	//--------------------------------------------------------------------
	initial
	begin
		Clk = 1'b0;
		rstN = 1'b0;
		run = 1'b0;
		resume = 1'b0;
		hostWe = 1'b0;
		hostAddr = '0;
		hostWrData = '0;
		void'($urandom(Seed));

		testResetState();
		testAluOps();
		testBranches();
		testJumps();
		testLoadStoreOffsets();
		testPause();

		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
+incdir+hw
+incdir+bench
hw/cpuPkg.sv
hw/controlSequencer.sv
hw/dataPath.sv
hw/wordMemory.sv
hw/cpuTop.sv
bench/cpuTb.sv

/* hw/controlSequencer.sv */
//--------------------------------------------------------------------
// Multi-cycle control FSM, drives datapath strobes and memory enables
// Halted until run, then loops fetch / decode / execute forever
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module controlSequencer
(
	input wire Clk,
	input wire rstN,
	input wire run,				// Level, leave halted
	input wire resume,			// Level, press then release
	input wire cpuPkg::opcodeT opcode,
	input wire irBit5,
	input wire irBit11,
	input wire ben,
	output logic ldMar,
	output logic ldMdr,
	output logic ldIr,
	output logic ldBen,
	output logic ldCc,
	output logic ldReg,
	output logic ldPc,
	output logic ldLed,
	output logic gatePc,
	output logic gateMdr,
	output logic gateAlu,
	output logic gateMarMux,
	output cpuPkg::pcMuxT pcMux,
	output logic drMux,			// 1: IR[11:9], 0: R7
	output logic sr1Mux,		// 1: IR[8:6], 0: IR[11:9]
	output logic sr2Mux,		// 1: imm5
	output logic addr1Mux,		// 1: PC, 0: SR1
	output cpuPkg::addr2MuxT addr2Mux,
	output cpuPkg::aluOpT aluOp,
	output logic memOeN,
	output logic memWeN,
	output logic paused
);

	cpuPkg::seqStateT state;
	cpuPkg::seqStateT stateNext;

	always_ff @(posedge Clk or negedge rstN)
	begin
		if (!rstN)
			state <= cpuPkg::stHalted;
		else
			state <= stateNext;
	end

	//--------------------------------------------------------------------
	// Next state and control decode
	//--------------------------------------------------------------------
	always_comb
	begin
		stateNext = state;				// Hold unless told otherwise
		ldMar = 1'b0;
		ldMdr = 1'b0;
		ldIr = 1'b0;
		ldBen = 1'b0;
		ldCc = 1'b0;
		ldReg = 1'b0;
		ldPc = 1'b0;
		ldLed = 1'b0;
		gatePc = 1'b0;
		gateMdr = 1'b0;
		gateAlu = 1'b0;
		gateMarMux = 1'b0;
		pcMux = cpuPkg::pcInc;
		drMux = 1'b0;
		sr1Mux = 1'b0;
		sr2Mux = 1'b0;
		addr1Mux = 1'b0;
		addr2Mux = cpuPkg::a2Off11;
		aluOp = cpuPkg::aluAdd;
		memOeN = 1'b1;					// Memory idle
		memWeN = 1'b1;
		paused = 1'b0;

		case (state)
			cpuPkg::stHalted:
				if (run)
					stateNext = cpuPkg::stFetchPc;
			cpuPkg::stPauseIr1:
				begin
					ldLed = 1'b1;			// LED <- IR[11:0]
					paused = 1'b1;
					if (resume)
						stateNext = cpuPkg::stPauseIr2;
				end
			cpuPkg::stPauseIr2:
				begin
					ldLed = 1'b1;
					paused = 1'b1;
					if (!resume)			// Released, go on
						stateNext = cpuPkg::stFetchPc;
				end
			cpuPkg::stFetchPc:
				begin
					gatePc = 1'b1;			// MAR <- PC
					ldMar = 1'b1;
					pcMux = cpuPkg::pcInc;	// PC <- PC + 1
					ldPc = 1'b1;
					stateNext = cpuPkg::stFetchRd1;
				end
			cpuPkg::stFetchRd1:
				begin
					memOeN = 1'b0;			// Registered read issued
					stateNext = cpuPkg::stFetchRd2;
				end
			cpuPkg::stFetchRd2:
				begin
					memOeN = 1'b0;
					ldMdr = 1'b1;			// MDR <- M[MAR]
					stateNext = cpuPkg::stFetchIr;
				end
			cpuPkg::stFetchIr:
				begin
					gateMdr = 1'b1;			// IR <- MDR
					ldIr = 1'b1;
					stateNext = cpuPkg::stDecode;
				end
			cpuPkg::stDecode:
				begin
					ldBen = 1'b1;			// BEN <- nzp & IR[11:9]
					case (opcode)
						cpuPkg::opAdd: stateNext = cpuPkg::stAdd;
						cpuPkg::opAnd: stateNext = cpuPkg::stAnd;
						cpuPkg::opNot: stateNext = cpuPkg::stNot;
						cpuPkg::opBr: stateNext = cpuPkg::stBr1;
						cpuPkg::opJmp: stateNext = cpuPkg::stJmp;
						cpuPkg::opJsr: stateNext = cpuPkg::stJsr1;
						cpuPkg::opLdr: stateNext = cpuPkg::stLdrAddr;
						cpuPkg::opStr: stateNext = cpuPkg::stStrAddr;
						cpuPkg::opPause: stateNext = cpuPkg::stPauseIr1;
						default: stateNext = cpuPkg::stFetchPc;	// Unknown, skip it
					endcase
				end
			cpuPkg::stAdd, cpuPkg::stAnd, cpuPkg::stNot:
				begin
					sr2Mux = irBit5;		// Register or imm5
					drMux = 1'b1;
					sr1Mux = 1'b1;
					if (state == cpuPkg::stAdd)
						aluOp = cpuPkg::aluAdd;
					else if (state == cpuPkg::stAnd)
						aluOp = cpuPkg::aluAnd;
					else
						aluOp = cpuPkg::aluNot;
					gateAlu = 1'b1;
					ldReg = 1'b1;
					ldCc = 1'b1;
					stateNext = cpuPkg::stFetchPc;
				end
			cpuPkg::stBr1:
				stateNext = ben ? cpuPkg::stBr2 : cpuPkg::stFetchPc;
			cpuPkg::stBr2:
				begin
					addr1Mux = 1'b1;		// PC + off9
					addr2Mux = cpuPkg::a2Off9;
					pcMux = cpuPkg::pcAdder;
					ldPc = 1'b1;
					stateNext = cpuPkg::stFetchPc;
				end
			cpuPkg::stJmp:
				begin
					sr1Mux = 1'b1;			// BaseR through ALU
					aluOp = cpuPkg::aluPass;
					gateAlu = 1'b1;
					pcMux = cpuPkg::pcBus;
					ldPc = 1'b1;
					stateNext = cpuPkg::stFetchPc;
				end
			cpuPkg::stJsr1:
				begin
					drMux = 1'b0;			// R7 <- PC
					gatePc = 1'b1;
					ldReg = 1'b1;
					stateNext = irBit11 ? cpuPkg::stJsrPcOff : cpuPkg::stJsrBase;
				end
			cpuPkg::stJsrPcOff:
				begin
					addr1Mux = 1'b1;		// PC + off11
					addr2Mux = cpuPkg::a2Off11;
					pcMux = cpuPkg::pcAdder;
					ldPc = 1'b1;
					stateNext = cpuPkg::stFetchPc;
				end
			cpuPkg::stJsrBase:
				begin
					sr1Mux = 1'b1;			// JSRR, PC <- BaseR + 0
					addr1Mux = 1'b0;
					addr2Mux = cpuPkg::a2Zero;
					pcMux = cpuPkg::pcAdder;
					ldPc = 1'b1;
					stateNext = cpuPkg::stFetchPc;
				end
			cpuPkg::stLdrAddr, cpuPkg::stStrAddr:
				begin
					sr1Mux = 1'b1;			// MAR <- BaseR + off6
					addr1Mux = 1'b0;
					addr2Mux = cpuPkg::a2Off6;
					gateMarMux = 1'b1;
					ldMar = 1'b1;
					if (state == cpuPkg::stLdrAddr)
						stateNext = cpuPkg::stLdrRd1;
					else
						stateNext = cpuPkg::stStrData;
				end
			cpuPkg::stLdrRd1:
				begin
					memOeN = 1'b0;
					stateNext = cpuPkg::stLdrRd2;
				end
			cpuPkg::stLdrRd2:
				begin
					memOeN = 1'b0;
					ldMdr = 1'b1;
					stateNext = cpuPkg::stLdrWb;
				end
			cpuPkg::stLdrWb:
				begin
					drMux = 1'b1;			// DR <- MDR
					gateMdr = 1'b1;
					ldReg = 1'b1;
					ldCc = 1'b1;
					stateNext = cpuPkg::stFetchPc;
				end
			cpuPkg::stStrData:
				begin
					sr1Mux = 1'b0;			// MDR <- SR from IR[11:9]
					aluOp = cpuPkg::aluPass;
					gateAlu = 1'b1;
					ldMdr = 1'b1;
					stateNext = cpuPkg::stStrWr1;
				end
			cpuPkg::stStrWr1:
				begin
					memWeN = 1'b0;
					stateNext = cpuPkg::stStrWr2;
				end
			cpuPkg::stStrWr2:
				begin
					memWeN = 1'b0;
					stateNext = cpuPkg::stStrWr3;
				end
			cpuPkg::stStrWr3:
				begin
					memWeN = 1'b0;
					stateNext = cpuPkg::stFetchPc;
				end
			default:
				stateNext = cpuPkg::stHalted;
		endcase
	end

endmodule

`default_nettype wire

/* hw/cpuConsts.svh */
//--------------------------------------------------------------------
// Sizing constants for the core, shared by the RTL and the testbench
//--------------------------------------------------------------------
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Data path and instruction word width
`define CPU_WORD_WIDTH 16

// Word address into on-chip memory, 256 words
`define CPU_MEM_ADDR_WIDTH 8

// PC value after reset
`define CPU_RESET_PC 16'h0000

`endif

/* hw/cpuPkg.sv */
//--------------------------------------------------------------------
// Enumerated types shared by the sequencer, datapath and testbench
//--------------------------------------------------------------------
`default_nettype none

package cpuPkg;

	typedef enum logic [3:0]
	{
		opBr    = 4'b0000,
		opAdd   = 4'b0001,
		opJsr   = 4'b0100,	// JSR and JSRR, split on IR[11]
		opAnd   = 4'b0101,
		opLdr   = 4'b0110,
		opStr   = 4'b0111,
		opNot   = 4'b1001,
		opJmp   = 4'b1100,
		opPause = 4'b1101	// Show IR[11:0] and wait for operator
	} opcodeT;

	// Sequencer states, in fetch / decode / execute order
	typedef enum logic [4:0]
	{
		stHalted, stPauseIr1, stPauseIr2,
		stFetchPc, stFetchRd1, stFetchRd2, stFetchIr, stDecode,
		stAdd, stAnd, stNot,
		stBr1, stBr2, stJmp,
		stJsr1, stJsrPcOff, stJsrBase,
		stLdrAddr, stLdrRd1, stLdrRd2, stLdrWb,
		stStrAddr, stStrData, stStrWr1, stStrWr2, stStrWr3
	} seqStateT;

	typedef enum logic [1:0]
	{
		pcInc   = 2'b00,	// PC + 1
		pcBus   = 2'b01,	// From bus
		pcAdder = 2'b10	// From address adder
	} pcMuxT;

	typedef enum logic [1:0]
	{
		a2Off11 = 2'b00,	// SEXT(IR[10:0])
		a2Off9  = 2'b01,	// SEXT(IR[8:0])
		a2Off6  = 2'b10,	// SEXT(IR[5:0])
		a2Zero  = 2'b11
	} addr2MuxT;

	typedef enum logic [1:0]
	{
		aluAdd  = 2'b00,
		aluAnd  = 2'b01,
		aluNot  = 2'b10,
		aluPass = 2'b11	// SR1 straight through
	} aluOpT;

endpackage

`default_nettype wire

/* hw/cpuTop.sv */
//--------------------------------------------------------------------
// Core top, sequencer plus datapath plus word memory
// Host port loads programs and reads results while halted or paused
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "cpuConsts.svh"

module cpuTop
(
	input wire Clk,
	input wire rstN,
	input wire run,
	input wire resume,
	input wire hostWe,
	input wire [`CPU_MEM_ADDR_WIDTH-1:0] hostAddr,
	input wire [`CPU_WORD_WIDTH-1:0] hostWrData,
	output logic [11:0] ledOut,
	output logic paused,
	output logic [`CPU_WORD_WIDTH-1:0] hostRdData
);

	// Load strobes
	logic ldMar;
	logic ldMdr;
	logic ldIr;
	logic ldBen;
	logic ldCc;
	logic ldReg;
	logic ldPc;
	logic ldLed;

	// Bus gates
	logic gatePc;
	logic gateMdr;
	logic gateAlu;
	logic gateMarMux;

	// Selects
	cpuPkg::pcMuxT pcMux;
	logic drMux;
	logic sr1Mux;
	logic sr2Mux;
	logic addr1Mux;
	cpuPkg::addr2MuxT addr2Mux;
	cpuPkg::aluOpT aluOp;

	// Status back to the FSM
	cpuPkg::opcodeT opcode;
	logic irBit5;
	logic irBit11;
	logic ben;

	// Memory side
	logic memOeN;
	logic memWeN;
	logic [`CPU_MEM_ADDR_WIDTH-1:0] memAddr;
	logic [`CPU_WORD_WIDTH-1:0] memWrData;
	logic [`CPU_WORD_WIDTH-1:0] memRdData;

	// Port names match across blocks
	controlSequencer sequencer (.*);

	dataPath path (.*);

	wordMemory memory (.*);

endmodule

`default_nettype wire

/* hw/dataPath.sv */
//--------------------------------------------------------------------
// Core datapath with PC, MAR, MDR, IR, CC, BEN, LED, registers, ALU
// All loads are strobed by the sequencer and take the bus at the edge
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "cpuConsts.svh"

module dataPath
(
	input wire Clk,
	input wire rstN,
	input wire ldMar,
	input wire ldMdr,
	input wire ldIr,
	input wire ldBen,
	input wire ldCc,
	input wire ldReg,
	input wire ldPc,
	input wire ldLed,
	input wire gatePc,
	input wire gateMdr,
	input wire gateAlu,
	input wire gateMarMux,
	input wire cpuPkg::pcMuxT pcMux,
	input wire drMux,
	input wire sr1Mux,
	input wire sr2Mux,
	input wire addr1Mux,
	input wire cpuPkg::addr2MuxT addr2Mux,
	input wire cpuPkg::aluOpT aluOp,
	input wire memOeN,			// Low: MDR takes memory, not bus
	input wire [`CPU_WORD_WIDTH-1:0] memRdData,
	output cpuPkg::opcodeT opcode,
	output logic irBit5,
	output logic irBit11,
	output logic ben,
	output logic [`CPU_MEM_ADDR_WIDTH-1:0] memAddr,
	output logic [`CPU_WORD_WIDTH-1:0] memWrData,
	output logic [11:0] ledOut
);

	logic [`CPU_WORD_WIDTH-1:0] pc;
	logic [`CPU_WORD_WIDTH-1:0] pcNext;
	logic [`CPU_MEM_ADDR_WIDTH-1:0] mar;	// Word address only
	logic [`CPU_WORD_WIDTH-1:0] mdr;
	logic [`CPU_WORD_WIDTH-1:0] ir;
	logic ccN;
	logic ccZ;
	logic ccP;
	logic [`CPU_WORD_WIDTH-1:0] regFile [8];
	logic [2:0] drSel;
	logic [2:0] sr1Sel;
	logic [`CPU_WORD_WIDTH-1:0] sr1Out;
	logic [`CPU_WORD_WIDTH-1:0] sr2Val;
	logic [`CPU_WORD_WIDTH-1:0] aluOut;
	logic [`CPU_WORD_WIDTH-1:0] addr1Val;
	logic [`CPU_WORD_WIDTH-1:0] addr2Val;
	logic [`CPU_WORD_WIDTH-1:0] adderOut;
	logic [`CPU_WORD_WIDTH-1:0] bus;

	//--------------------------------------------------------------------
	// Register file, ALU and address adder
	//--------------------------------------------------------------------
	assign drSel = drMux ? ir[11:9] : 3'd7;		// R7 for JSR link
	assign sr1Sel = sr1Mux ? ir[8:6] : ir[11:9];
	assign sr1Out = regFile[sr1Sel];
	assign sr2Val = sr2Mux ? {{(`CPU_WORD_WIDTH-5){ir[4]}}, ir[4:0]} : regFile[ir[2:0]];

	always_ff @(posedge Clk)
	begin
		if (ldReg)
			regFile[drSel] <= bus;
	end

	always_comb
	begin
		case (aluOp)
			cpuPkg::aluAdd: aluOut = sr1Out + sr2Val;
			cpuPkg::aluAnd: aluOut = sr1Out & sr2Val;
			cpuPkg::aluNot: aluOut = ~sr1Out;
			default: aluOut = sr1Out;	// Pass
		endcase
	end

	assign addr1Val = addr1Mux ? pc : sr1Out;

	always_comb
	begin
		case (addr2Mux)
			cpuPkg::a2Off11: addr2Val = {{(`CPU_WORD_WIDTH-11){ir[10]}}, ir[10:0]};
			cpuPkg::a2Off9: addr2Val = {{(`CPU_WORD_WIDTH-9){ir[8]}}, ir[8:0]};
			cpuPkg::a2Off6: addr2Val = {{(`CPU_WORD_WIDTH-6){ir[5]}}, ir[5:0]};
			default: addr2Val = '0;
		endcase
	end

	assign adderOut = addr1Val + addr2Val;

	// One gate at a time, idle bus reads zero
	always_comb
	begin
		if (gatePc)
			bus = pc;
		else if (gateMdr)
			bus = mdr;
		else if (gateAlu)
			bus = aluOut;
		else if (gateMarMux)
			bus = adderOut;
		else
			bus = '0;
	end

	always_comb
	begin
		case (pcMux)
			cpuPkg::pcInc: pcNext = pc + 1'b1;
			cpuPkg::pcBus: pcNext = bus;
			cpuPkg::pcAdder: pcNext = adderOut;
			default: pcNext = pc;
		endcase
	end

	//--------------------------------------------------------------------
	// Architectural and control registers
	//--------------------------------------------------------------------
	always_ff @(posedge Clk or negedge rstN)
	begin
		if (!rstN)
		begin
			pc <= `CPU_RESET_PC;
			ir <= '0;
			ccN <= 1'b0;
			ccZ <= 1'b0;
			ccP <= 1'b0;
			ben <= 1'b0;
			ledOut <= '0;
		end
		else
		begin
			if (ldPc)
				pc <= pcNext;
			if (ldIr)
				ir <= bus;
			if (ldCc)
			begin
				ccN <= bus[`CPU_WORD_WIDTH-1];		// Sign bit
				ccZ <= (bus == '0);
				ccP <= !bus[`CPU_WORD_WIDTH-1] && (bus != '0);
			end
			if (ldBen)
				ben <= |(ir[11:9] & {ccN, ccZ, ccP});
			if (ldLed)
				ledOut <= ir[11:0];
		end
	end

	// MAR and MDR carry payload only
	always_ff @(posedge Clk)
	begin
		if (ldMar)
			mar <= bus[`CPU_MEM_ADDR_WIDTH-1:0];	// Low PC bits address memory
		if (ldMdr)
			mdr <= memOeN ? bus : memRdData;
	end

	assign opcode = cpuPkg::opcodeT'(ir[15:12]);
	assign irBit5 = ir[5];
	assign irBit11 = ir[11];
	assign memAddr = mar;
	assign memWrData = mdr;

endmodule

`default_nettype wire

/* hw/wordMemory.sv */
//--------------------------------------------------------------------
// On-chip word RAM, strobed core port plus a host port for loading
// Contents are kept across reset
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "cpuConsts.svh"

module wordMemory
(
	input wire Clk,
	input wire memOeN,			// Low: registered read of memAddr
	input wire memWeN,			// Low: write every edge
	input wire [`CPU_MEM_ADDR_WIDTH-1:0] memAddr,
	input wire [`CPU_WORD_WIDTH-1:0] memWrData,
	input wire hostWe,
	input wire [`CPU_MEM_ADDR_WIDTH-1:0] hostAddr,
	input wire [`CPU_WORD_WIDTH-1:0] hostWrData,
	output logic [`CPU_WORD_WIDTH-1:0] memRdData,
	output logic [`CPU_WORD_WIDTH-1:0] hostRdData
);

	localparam int Depth = 1 << `CPU_MEM_ADDR_WIDTH;

	logic [`CPU_WORD_WIDTH-1:0] mem [Depth];

	always_ff @(posedge Clk)
	begin
		if (!memWeN)
			mem[memAddr] <= memWrData;
		if (hostWe)
			mem[hostAddr] <= hostWrData;	// Host only while core is idle
		if (!memOeN)
			memRdData <= mem[memAddr];		// Holds last word otherwise
		hostRdData <= mem[hostAddr];
	end

endmodule

`default_nettype wire
